/* hw/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data word and physical address width
`define CPU_WORD_W 16
`define CPU_PADDR_W 10

// 64-word pages make translation a bit concatenation
`define CPU_PAGE_BITS 6
`define CPU_NUM_PAGES 16

// only the low bits of reg_num select a register
`define CPU_NUM_REGS 16
`define CPU_RESET_PC 0

// any other opcode executes as a no-op
`define CPU_OP_JMP 1
`define CPU_OP_RAM2REG 2
`define CPU_OP_REG2RAM 3
`define CPU_OP_NUM2REG 4
`define CPU_OP_PLUS 5
`define CPU_OP_MINUS 6
`define CPU_OP_EXIT 17

`endif

/* hw/cpu_pkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [`CPU_WORD_W-1:0] laddr_t;
  typedef logic [`CPU_PADDR_W-1:0] paddr_t;

  // page numbers are the address bits above the page offset
  typedef logic [`CPU_WORD_W-`CPU_PAGE_BITS-1:0] lpage_t;
  typedef logic [`CPU_PADDR_W-`CPU_PAGE_BITS-1:0] ppage_t;

  typedef enum logic [7:0] {
    OP_JMP     = 8'(`CPU_OP_JMP),
    OP_RAM2REG = 8'(`CPU_OP_RAM2REG),
    OP_REG2RAM = 8'(`CPU_OP_REG2RAM),
    OP_NUM2REG = 8'(`CPU_OP_NUM2REG),
    OP_PLUS    = 8'(`CPU_OP_PLUS),
    OP_MINUS   = 8'(`CPU_OP_MINUS),
    OP_EXIT    = 8'(`CPU_OP_EXIT)
  } opcode_e;

  // first word is {opcode, reg_num}, second word is the operand
  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] reg_num;
    word_t      operand;
  } instr_t;

  typedef struct packed {
    logic   write;
    paddr_t addr;
    word_t  wdata;
  } mem_req_t;

  typedef struct packed {
    paddr_t paddr;
    logic   fault;  // no free physical page left
  } xlate_rsp_t;

endpackage

`default_nettype wire

/* hw/page_mapper.sv */
`default_nettype none

`include "cpu_consts.svh"

module page_mapper (
  input  logic                clka,
  input  logic                rst,
  input  logic                valid,
  input  cpu_pkg::laddr_t     laddr,
  output logic                done,
  output cpu_pkg::xlate_rsp_t rsp
);

  typedef enum logic [1:0] {
    PM_IDLE,
    PM_WALK,  // follow chain from page 0
    PM_SCAN   // look for a free page to append
  } pm_state_e;

  pm_state_e state;

  // chain of next-page indices, index 0 marks the chain end
  cpu_pkg::ppage_t chain_tbl [`CPU_NUM_PAGES];
  cpu_pkg::lpage_t tag_tbl [`CPU_NUM_PAGES];
  logic [`CPU_NUM_PAGES-1:0] used;

  cpu_pkg::lpage_t in_lpage;
  cpu_pkg::lpage_t req_lpage;
  logic [`CPU_PAGE_BITS-1:0] req_off;
  cpu_pkg::lpage_t last_lpage;  // last successful translation
  cpu_pkg::ppage_t last_ppage;
  cpu_pkg::ppage_t cur;         // page visited by the walk
  cpu_pkg::ppage_t alloc_ptr;

  assign in_lpage = laddr[`CPU_WORD_W-1:`CPU_PAGE_BITS];

  always_ff @(posedge clka) begin
    if (!rst) begin
      state        <= PM_IDLE;
      done         <= 1'b0;
      used         <= `CPU_NUM_PAGES'(1);  // page 0 holds logical page 0
      chain_tbl[0] <= '0;
      tag_tbl[0]   <= '0;
      last_lpage   <= '0;
      last_ppage   <= '0;
      cur          <= '0;
      alloc_ptr    <= cpu_pkg::ppage_t'(1);
    end else begin
      done <= 1'b0;
      case (state)
        PM_IDLE: begin
          if (valid) begin
            req_lpage <= in_lpage;
            req_off   <= laddr[`CPU_PAGE_BITS-1:0];
            if (in_lpage == last_lpage) begin
              done      <= 1'b1;  // same page as last time
              rsp.paddr <= {last_ppage, laddr[`CPU_PAGE_BITS-1:0]};
              rsp.fault <= 1'b0;
            end else begin
              cur   <= '0;
              state <= PM_WALK;
            end
          end
        end
        PM_WALK: begin
          if (tag_tbl[cur] == req_lpage) begin
            done       <= 1'b1;
            rsp.paddr  <= {cur, req_off};
            rsp.fault  <= 1'b0;
            last_lpage <= req_lpage;
            last_ppage <= cur;
            state      <= PM_IDLE;
          end else if (chain_tbl[cur] == '0) begin
            state <= PM_SCAN;  // cur stays as chain tail
          end else begin
            cur <= chain_tbl[cur];
          end
        end
        PM_SCAN: begin
          if (!used[alloc_ptr]) begin
            used[alloc_ptr]      <= 1'b1;
            tag_tbl[alloc_ptr]   <= req_lpage;
            chain_tbl[alloc_ptr] <= '0;         // new chain end
            chain_tbl[cur]       <= alloc_ptr;  // link behind old tail
            done                 <= 1'b1;
            rsp.paddr            <= {alloc_ptr, req_off};
            rsp.fault            <= 1'b0;
            last_lpage           <= req_lpage;
            last_ppage           <= alloc_ptr;
            state                <= PM_IDLE;
          end else if (alloc_ptr == cpu_pkg::ppage_t'(`CPU_NUM_PAGES - 1)) begin
            done      <= 1'b1;  // out of pages
            rsp.paddr <= '0;
            rsp.fault <= 1'b1;
            state     <= PM_IDLE;
          end else begin
            alloc_ptr <= alloc_ptr + 1'b1;
          end
        end
        default: state <= PM_IDLE;
      endcase
    end
  end

  // chain links only ever point at allocated pages
  a_walk_used: assert property (@(posedge clka) disable iff (!rst)
    (state == PM_WALK) |-> used[cur])
    else $error("chain walk reached unused page %0d", cur);

endmodule

`default_nettype wire

/* hw/apb_requester.sv */
`default_nettype none

module apb_requester (
  input  logic              clka,
  input  logic              rst,
  input  logic              req_valid,
  input  cpu_pkg::mem_req_t req,
  output logic              done,
  output cpu_pkg::word_t    rdata,
  output cpu_pkg::paddr_t   paddr,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output cpu_pkg::word_t    pwdata,
  input  cpu_pkg::word_t    prdata,
  input  logic              pready
);

  typedef enum logic [1:0] {
    AP_IDLE,
    AP_SETUP,
    AP_ACCESS
  } apb_state_e;

  apb_state_e state;

  assign psel    = (state != AP_IDLE);
  assign penable = (state == AP_ACCESS);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state  <= AP_IDLE;
      pwrite <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        AP_IDLE: begin
          if (req_valid) begin
            paddr  <= req.addr;  // held until completion
            pwrite <= req.write;
            pwdata <= req.wdata;
            state  <= AP_SETUP;
          end
        end
        AP_SETUP: state <= AP_ACCESS;
        AP_ACCESS: begin
          if (pready) begin  // wait states keep us here
            rdata <= prdata;
            done  <= 1'b1;
            state <= AP_IDLE;
          end
        end
        default: state <= AP_IDLE;
      endcase
    end
  end

  a_enable_sel: assert property (@(posedge clka) disable iff (!rst)
    penable |-> psel)
    else $error("penable without psel");

  a_addr_stable: assert property (@(posedge clka) disable iff (!rst)
    (psel && !pready) |=> $stable(paddr))
    else $error("paddr changed during a transfer");

endmodule

`default_nettype wire

/* hw/cpu_sequencer.sv */
`default_nettype none

`include "cpu_consts.svh"

module cpu_sequencer (
  input  logic                clka,
  input  logic                rst,
  output logic                xlate_valid,
  output cpu_pkg::laddr_t     xlate_laddr,
  input  logic                xlate_done,
  input  cpu_pkg::xlate_rsp_t xlate_rsp,
  output logic                req_valid,
  output cpu_pkg::mem_req_t   req,
  input  logic                done,
  input  cpu_pkg::word_t      rdata,
  output logic                halted,
  output logic                page_fault
);

  typedef enum logic [2:0] {
    ST_XLATE,  // issue translation
    ST_XWAIT,  // wait for mapper, then issue memory access
    ST_MWAIT,  // wait for bus completion
    ST_EXEC,
    ST_HALT
  } seq_state_e;

  // which access the current translate/read pair belongs to
  typedef enum logic [1:0] {
    PH_FETCH1,
    PH_FETCH2,
    PH_DATA
  } phase_e;

  seq_state_e      state;
  phase_e          phase;
  cpu_pkg::laddr_t pc;
  cpu_pkg::instr_t instr;

  cpu_pkg::word_t regs [`CPU_NUM_REGS];
  logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx;
  logic           rf_we;
  cpu_pkg::word_t rf_wdata;
  logic           is_store;

  assign reg_idx  = instr.reg_num[$clog2(`CPU_NUM_REGS)-1:0];
  assign is_store = (phase == PH_DATA) && (instr.opcode == cpu_pkg::OP_REG2RAM);

  // register file writes from execute and from RAM2REG read data
  always_comb begin
    rf_we    = 1'b0;
    rf_wdata = instr.operand;
    case (state)
      ST_EXEC: begin
        case (instr.opcode)
          cpu_pkg::OP_NUM2REG: rf_we = 1'b1;
          cpu_pkg::OP_PLUS: begin
            rf_we    = 1'b1;
            rf_wdata = regs[reg_idx] + instr.operand;  // wraps at 16 bits
          end
          cpu_pkg::OP_MINUS: begin
            rf_we    = 1'b1;
            rf_wdata = regs[reg_idx] - instr.operand;
          end
          default: rf_we = 1'b0;
        endcase
      end
      ST_MWAIT: begin
        if (done && phase == PH_DATA && instr.opcode == cpu_pkg::OP_RAM2REG) begin
          rf_we    = 1'b1;
          rf_wdata = rdata;
        end
      end
      default: rf_we = 1'b0;
    endcase
  end

  always_ff @(posedge clka) begin
    if (rf_we) begin
      regs[reg_idx] <= rf_wdata;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      state       <= ST_XLATE;
      phase       <= PH_FETCH1;
      pc          <= cpu_pkg::laddr_t'(`CPU_RESET_PC);
      xlate_valid <= 1'b0;
      req_valid   <= 1'b0;
      halted      <= 1'b0;
      page_fault  <= 1'b0;
    end else begin
      xlate_valid <= 1'b0;  // both requests are single-cycle pulses
      req_valid   <= 1'b0;
      case (state)
        ST_XLATE: begin
          xlate_valid <= 1'b1;
          xlate_laddr <= (phase == PH_DATA) ? instr.operand : pc;
          state       <= ST_XWAIT;
        end
        ST_XWAIT: begin
          if (xlate_done) begin
            if (xlate_rsp.fault) begin
              page_fault <= 1'b1;
              halted     <= 1'b1;
              state      <= ST_HALT;
            end else begin
              req.write <= is_store;
              req.addr  <= xlate_rsp.paddr;
              req.wdata <= regs[reg_idx];  // only meaningful for REG2RAM
              req_valid <= 1'b1;
              state     <= ST_MWAIT;
            end
          end
        end
        ST_MWAIT: begin
          if (done) begin
            case (phase)
              PH_FETCH1: begin
                instr.opcode  <= rdata[15:8];
                instr.reg_num <= rdata[7:0];
                pc            <= pc + 1'b1;
                phase         <= PH_FETCH2;
                state         <= ST_XLATE;
              end
              PH_FETCH2: begin
                instr.operand <= rdata;
                pc            <= pc + 1'b1;
                state         <= ST_EXEC;
              end
              default: begin  // data access finished
                phase <= PH_FETCH1;
                state <= ST_XLATE;
              end
            endcase
          end
        end
        ST_EXEC: begin
          case (instr.opcode)
            cpu_pkg::OP_JMP: begin
              pc    <= instr.operand;
              phase <= PH_FETCH1;
              state <= ST_XLATE;
            end
            cpu_pkg::OP_RAM2REG, cpu_pkg::OP_REG2RAM: begin
              phase <= PH_DATA;
              state <= ST_XLATE;
            end
            cpu_pkg::OP_EXIT: begin
              halted <= 1'b1;
              state  <= ST_HALT;
            end
            default: begin  // register ops and no-ops
              phase <= PH_FETCH1;
              state <= ST_XLATE;
            end
          endcase
        end
        ST_HALT: state <= ST_HALT;  // nothing issued from here on
        default: state <= ST_HALT;
      endcase
    end
  end

  // mapper and bus are never busy for the sequencer at once
  a_one_request: assert property (@(posedge clka) disable iff (!rst)
    !(req_valid && xlate_valid))
    else $error("translation and memory request issued together");

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`default_nettype none

module cpu_top (
  input  logic            clka,
  input  logic            rst,
  output cpu_pkg::paddr_t paddr,
  output logic            psel,
  output logic            penable,
  output logic            pwrite,
  output cpu_pkg::word_t  pwdata,
  input  cpu_pkg::word_t  prdata,
  input  logic            pready,
  output logic            halted,
  output logic            page_fault
);

  logic                xlate_valid;
  cpu_pkg::laddr_t     xlate_laddr;
  logic                xlate_done;
  cpu_pkg::xlate_rsp_t xlate_rsp;
  logic                req_valid;
  cpu_pkg::mem_req_t   req;
  logic                mem_done;
  cpu_pkg::word_t      mem_rdata;

  cpu_sequencer u_seq (
    .clka        (clka),
    .rst         (rst),
    .xlate_valid (xlate_valid),
    .xlate_laddr (xlate_laddr),
    .xlate_done  (xlate_done),
    .xlate_rsp   (xlate_rsp),
    .req_valid   (req_valid),
    .req         (req),
    .done        (mem_done),
    .rdata       (mem_rdata),
    .halted      (halted),
    .page_fault  (page_fault)
  );

  page_mapper u_mmu (
    .clka  (clka),
    .rst   (rst),
    .valid (xlate_valid),
    .laddr (xlate_laddr),
    .done  (xlate_done),
    .rsp   (xlate_rsp)
  );

  apb_requester u_apb (
    .clka      (clka),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .done      (mem_done),
    .rdata     (mem_rdata),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready)
  );

endmodule

`default_nettype wire

/* bench/apb_mem_slave.sv */
`default_nettype none

module apb_mem_slave (
  input  logic            clka,
  input  cpu_pkg::paddr_t paddr,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  cpu_pkg::word_t  pwdata,
  output cpu_pkg::word_t  prdata,
  output logic            pready
);
  timeunit 1ns;
  timeprecision 100ps;

  cpu_pkg::word_t mem [1024];  // filled by the testbench
  integer         seed;
  int             waits;       // wait states left in this transfer

  initial begin
    seed   = 32'h6b48;
    pready = 1'b0;
    prdata = '0;
    waits  = 0;
  end

  always @(posedge clka) begin
    if (psel && !penable) begin  // setup phase seen
      waits = int'($unsigned($random(seed)) % 4);
      #2;
      pready = (waits == 0);
      prdata = mem[paddr];
    end else if (psel && penable && pready) begin
      if (pwrite) begin
        mem[paddr] = pwdata;  // write lands on completion
      end
      #2;
      pready = 1'b0;
    end else if (psel && penable) begin
      waits = waits - 1;
      #2;
      pready = (waits == 0);
    end
  end

endmodule

`default_nettype wire

/* bench/tb_cpu.sv */
`default_nettype none

`include "cpu_consts.svh"

module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;

  logic              clka;
  logic              rst;
  cpu_pkg::paddr_t   paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  cpu_pkg::word_t    pwdata;
  cpu_pkg::word_t    prdata;
  logic              pready;
  logic              halted;
  logic              page_fault;

  integer            seed;
  cpu_pkg::word_t    model_mem [1024];
  int                page_of [1024];  // physical page per logical page or -1
  int                next_free;
  logic              exp_fault;
  cpu_pkg::mem_req_t exp_q [$];       // transfers the core should make in order
  cpu_pkg::mem_req_t exp_x;

  cpu_top dut (
    .clka       (clka),
    .rst        (rst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .halted     (halted),
    .page_fault (page_fault)
  );

  apb_mem_slave u_mem (
    .clka    (clka),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready)
  );

  always #10 clka = ~clka;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0d ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic put_word(input int a, input cpu_pkg::word_t w);
    u_mem.mem[a] = w;
    model_mem[a] = w;
  endtask

  task automatic put_instr(input int idx, input int op, input int rn,
                           input cpu_pkg::word_t operand);
    put_word(2 * idx, {8'(op), 4'(rand_below(16)), 4'(rn)});  // upper reg bits ignored
    put_word(2 * idx + 1, operand);
  endtask

  task automatic gen_random_program();
    int              i;
    cpu_pkg::laddr_t daddr;
    for (i = 0; i < 4; i++) begin
      put_instr(i, `CPU_OP_NUM2REG, i, cpu_pkg::word_t'($random(seed)));
    end
    for (i = 4; i < 19; i++) begin
      daddr = {cpu_pkg::lpage_t'(1 + rand_below(6)), 6'(rand_below(64))};
      case (rand_below(6))
        0: put_instr(i, `CPU_OP_JMP, 0, cpu_pkg::word_t'(2 * (i + 1 + rand_below(19 - i))));
        1: put_instr(i, `CPU_OP_RAM2REG, rand_below(4), daddr);
        2: put_instr(i, `CPU_OP_REG2RAM, rand_below(4), daddr);
        3: put_instr(i, `CPU_OP_NUM2REG, rand_below(4), cpu_pkg::word_t'($random(seed)));
        4: put_instr(i, `CPU_OP_PLUS, rand_below(4), cpu_pkg::word_t'($random(seed)));
        default: put_instr(i, `CPU_OP_MINUS, rand_below(4), cpu_pkg::word_t'($random(seed)));
      endcase
    end
    put_instr(19, `CPU_OP_EXIT, 0, '0);
  endtask

  // touches logical pages 1 to 16 which is one more than the free pages
  task automatic gen_exhaust_program();
    int k;
    put_instr(0, `CPU_OP_NUM2REG, 1, cpu_pkg::word_t'($random(seed)));
    for (k = 1; k <= 16; k++) begin
      put_instr(k, (k % 2 == 1) ? `CPU_OP_REG2RAM : `CPU_OP_RAM2REG, 1,
                {cpu_pkg::lpage_t'(k), 6'(rand_below(64))});
    end
    put_instr(17, `CPU_OP_EXIT, 0, '0);
  endtask

  // first-fit allocation in order of first touch
  task automatic model_xlate(input cpu_pkg::laddr_t la, output cpu_pkg::paddr_t pa,
                             output logic fault);
    int lp;
    lp    = int'(la[`CPU_WORD_W-1:`CPU_PAGE_BITS]);
    fault = 1'b0;
    pa    = '0;
    if (page_of[lp] < 0) begin
      if (next_free >= `CPU_NUM_PAGES) begin
        fault = 1'b1;
      end else begin
        page_of[lp] = next_free;
        next_free   = next_free + 1;
      end
    end
    if (!fault) begin
      pa = {cpu_pkg::ppage_t'(page_of[lp]), la[`CPU_PAGE_BITS-1:0]};
    end
  endtask

  task automatic run_model();
    cpu_pkg::laddr_t pc;
    cpu_pkg::paddr_t pa;
    cpu_pkg::word_t  w0;
    cpu_pkg::word_t  w1;
    cpu_pkg::word_t  regs [`CPU_NUM_REGS];
    logic            f;
    int              steps;
    exp_q.delete();
    foreach (page_of[p]) page_of[p] = -1;
    page_of[0] = 0;  // program page is mapped from reset
    next_free  = 1;
    exp_fault  = 1'b0;
    pc         = cpu_pkg::laddr_t'(`CPU_RESET_PC);
    steps      = 0;
    while (steps < 1000) begin
      steps = steps + 1;
      model_xlate(pc, pa, f);
      w0 = model_mem[pa];
      exp_q.push_back({1'b0, pa, 16'h0});
      model_xlate(pc + 1'b1, pa, f);
      w1 = model_mem[pa];
      exp_q.push_back({1'b0, pa, 16'h0});
      pc = pc + 2'd2;
      case (w0[15:8])
        `CPU_OP_JMP: pc = w1;
        `CPU_OP_NUM2REG: regs[w0[3:0]] = w1;
        `CPU_OP_PLUS: regs[w0[3:0]] = regs[w0[3:0]] + w1;
        `CPU_OP_MINUS: regs[w0[3:0]] = regs[w0[3:0]] - w1;
        `CPU_OP_RAM2REG, `CPU_OP_REG2RAM: begin
          model_xlate(w1, pa, f);
          if (f) begin
            exp_fault = 1'b1;
            steps     = 1000;
          end else if (w0[15:8] == `CPU_OP_RAM2REG) begin
            regs[w0[3:0]] = model_mem[pa];
            exp_q.push_back({1'b0, pa, 16'h0});
          end else begin
            model_mem[pa] = regs[w0[3:0]];
            exp_q.push_back({1'b1, pa, regs[w0[3:0]]});
          end
        end
        `CPU_OP_EXIT: steps = 1000;
        default: ;  // no-op
      endcase
    end
  endtask

  // every completed transfer against the next one the model predicts
  always @(posedge clka) begin
    if (rst && psel && penable && pready) begin
      if (exp_q.size() == 0) begin
        report_failure("The core made an APB transfer that the model does not predict");
      end else begin
        exp_x = exp_q.pop_front();
        check_eq(32'(pwrite), 32'(exp_x.write), "pwrite");
        check_eq(32'(paddr), 32'(exp_x.addr), "paddr");
        if (exp_x.write) begin
          check_eq(32'(pwdata), 32'(exp_x.wdata), "pwdata");
        end
      end
    end
  end

  initial begin
    int run;
    int i;
    int n;
    seed = 32'h6b48;
    clka = 1'b0;
    rst  = 1'b0;
    for (run = 0; run < 2; run++) begin
      #2;
      rst = 1'b0;
      for (i = 0; i < 1024; i++) begin
        put_word(i, cpu_pkg::word_t'($random(seed)));
      end
      if (run == 0) begin
        gen_random_program();
      end else begin
        gen_exhaust_program();
      end
      run_model();
      repeat (5) @(posedge clka);
      #2;
      check_eq(psel, 0, "psel in reset");
      check_eq(penable, 0, "penable in reset");
      check_eq(halted, 0, "halted in reset");
      check_eq(page_fault, 0, "page_fault in reset");
      rst = 1'b1;
      n = 0;
      while (!halted && n < 20000) begin
        @(posedge clka);
        n = n + 1;
      end
      if (!halted) begin
        report_failure("The core did not halt within 20000 cycles");
      end
      #2;
      check_eq(page_fault, exp_fault, "page_fault at halt");
      check_eq(exp_q.size(), 0, "transfers still expected at halt");
      for (n = 0; n < 50; n++) begin  // bus stays quiet once halted
        @(posedge clka);
        check_eq(psel, 0, "psel after halt");
      end
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/cpu_pkg.sv
hw/page_mapper.sv
hw/apb_requester.sv
hw/cpu_sequencer.sv
hw/cpu_top.sv
bench/apb_mem_slave.sv
bench/tb_cpu.sv
